//--- hdl/clutCache.sv
module clutCache (
	input  logic clk,
	input  logic reset,
	input  logic [clutPkg::clutIdWidth-1:0] clutId,
	output logic clutChanged,

	clutFillIf.cache fillPort,

	input  logic reqValid1,
	input  logic [clutPkg::indexWidth-1:0] reqIdx1,
	output logic reqReady1,
	output logic colorValid1,
	output logic [clutPkg::colorWidth-1:0] color1,

	input  logic reqValid2,
	input  logic [clutPkg::indexWidth-1:0] reqIdx2,
	output logic reqReady2,
	output logic colorValid2,
	output logic [clutPkg::colorWidth-1:0] color2
);

	logic [clutPkg::wordWidth-1:0] storage [clutPkg::storageWords];
	logic [clutPkg::blockCount-1:0] loaded;
	logic [clutPkg::clutIdWidth-1:0] clutIdReg;
	logic [clutPkg::storageAddrWidth-1:0] writeAddr;
	logic lastWord;
	logic [clutPkg::indexWidth-1:0] readIdx1;
	logic [clutPkg::indexWidth-1:0] readIdx2;
	logic [clutPkg::wordWidth-1:0] word1;
	logic [clutPkg::wordWidth-1:0] word2;

	// Any difference from last cycle's identifier invalidates the whole table
	always_ff @(posedge clk) begin
		clutIdReg <= clutId;
	end

	assign clutChanged = (clutId != clutIdReg);

	assign writeAddr = {fillPort.blockIdx, fillPort.wordIdx};
	assign lastWord = (fillPort.wordIdx == clutPkg::wordIdxWidth'(clutPkg::wordsPerBlock - 1));

	always_ff @(posedge clk) begin
		if (fillPort.write) begin
			storage[writeAddr] <= fillPort.data;
		end
	end

	// Words arrive in order, so the block is exposed only once its last word
	// is in storage. Otherwise a hit on a later word could read stale data
	always_ff @(posedge clk) begin
		if (reset || clutChanged) begin
			loaded <= '0;
		end else if (fillPort.write && lastWord) begin
			loaded[fillPort.blockIdx] <= 1'b1;
		end
	end

	// Hit is combinational and doubles as the ready of each texel port
	assign reqReady1 = reqValid1
		&& loaded[reqIdx1[clutPkg::indexWidth-1 -: clutPkg::blockIdxWidth]];
	assign reqReady2 = reqValid2
		&& loaded[reqIdx2[clutPkg::indexWidth-1 -: clutPkg::blockIdxWidth]];

	always_ff @(posedge clk) begin
		if (reqReady1) begin
			readIdx1 <= reqIdx1;
		end
		if (reqReady2) begin
			readIdx2 <= reqIdx2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			colorValid1 <= 1'b0;
			colorValid2 <= 1'b0;
		end else begin
			colorValid1 <= reqReady1;
			colorValid2 <= reqReady2;
		end
	end

	// Upper seven index bits pick the word, bit 0 picks the half
	assign word1 = storage[readIdx1[clutPkg::indexWidth-1:1]];
	assign word2 = storage[readIdx2[clutPkg::indexWidth-1:1]];

	assign color1 = readIdx1[0] ? word1[clutPkg::wordWidth-1 -: clutPkg::colorWidth]
		: word1[clutPkg::colorWidth-1:0];
	assign color2 = readIdx2[0] ? word2[clutPkg::wordWidth-1 -: clutPkg::colorWidth]
		: word2[clutPkg::colorWidth-1:0];

endmodule

//--- hdl/clutFill.sv
module clutFill (
	input  logic clk,
	input  logic reset,
	input  logic [clutPkg::clutIdWidth-1:0] clutId,
	input  logic clutChanged,

	input  logic reqValid1,
	input  logic [clutPkg::indexWidth-1:0] reqIdx1,
	input  logic hit1,
	input  logic reqValid2,
	input  logic [clutPkg::indexWidth-1:0] reqIdx2,
	input  logic hit2,

	clutFillIf.fill fillPort,

	output logic pSel,
	output logic pEnable,
	output logic pWrite,
	output logic [clutPkg::addrWidth-1:0] pAddr,
	input  logic [clutPkg::wordWidth-1:0] pRdata,
	input  logic pReady
);

	clutPkg::fillState state;
	logic [clutPkg::clutIdWidth-1:0] fillId;
	logic [clutPkg::blockIdxWidth-1:0] blockIdx;
	logic [clutPkg::wordIdxWidth-1:0] wordIdx;
	logic abort;
	logic miss1;
	logic miss2;
	logic wordDone;

	assign miss1 = reqValid1 && !hit1;
	assign miss2 = reqValid2 && !hit2;
	assign wordDone = (state == clutPkg::access) && pReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= clutPkg::idle;
			wordIdx <= '0;
			abort <= 1'b0;
		end else begin
			case (state)
				clutPkg::idle: begin
					abort <= 1'b0;
					wordIdx <= '0;
					if (miss1 || miss2) begin
						state <= clutPkg::setup;
					end
				end
				clutPkg::setup: begin
					state <= clutPkg::access;
					if (clutChanged) begin
						abort <= 1'b1;
					end
				end
				clutPkg::access: begin
					if (pReady) begin
						// A palette change makes the rest of this block worthless
						if (abort || clutChanged) begin
							state <= clutPkg::idle;
						end else if (wordIdx == clutPkg::wordIdxWidth'(clutPkg::wordsPerBlock - 1)) begin
							state <= clutPkg::done;
						end else begin
							wordIdx <= wordIdx + 1'b1;
							state <= clutPkg::setup;
						end
					end else if (clutChanged) begin
						abort <= 1'b1;
					end
				end
				default: begin
					state <= clutPkg::idle;
				end
			endcase
		end
	end

	// Port 1 wins when both ports miss
	always_ff @(posedge clk) begin
		if (state == clutPkg::idle) begin
			fillId <= clutId;
			blockIdx <= miss1 ? reqIdx1[clutPkg::indexWidth-1 -: clutPkg::blockIdxWidth]
				: reqIdx2[clutPkg::indexWidth-1 -: clutPkg::blockIdxWidth];
		end
	end

	assign pSel = (state == clutPkg::setup) || (state == clutPkg::access);
	assign pEnable = (state == clutPkg::access);
	assign pWrite = 1'b0;
	assign pAddr = {fillId, blockIdx, wordIdx, 2'b00};

	// The returned word goes straight into the cache on the pReady cycle
	assign fillPort.write = wordDone && !abort && !clutChanged;
	assign fillPort.blockIdx = blockIdx;
	assign fillPort.wordIdx = wordIdx;
	assign fillPort.data = pRdata;

endmodule

//--- hdl/clutFillIf.sv
interface clutFillIf;

	// One pulse per stored word during a block fill
	logic write;

	// Held for the whole fill of one block
	logic [clutPkg::blockIdxWidth-1:0] blockIdx;

	logic [clutPkg::wordIdxWidth-1:0] wordIdx;
	logic [clutPkg::wordWidth-1:0] data;

	modport fill (
		output write,
		output blockIdx,
		output wordIdx,
		output data
	);

	modport cache (
		input write,
		input blockIdx,
		input wordIdx,
		input data
	);

endinterface

//--- hdl/clutPkg.sv
package clutPkg;

	// Palette identifier and texel index sizes
	localparam int clutIdWidth = 15;
	localparam int indexWidth = 8;

	// One storage word packs two 16-bit colours
	localparam int colorWidth = 16;
	localparam int wordWidth = 32;

	// A block is 16 colours, so the upper four index bits select it
	localparam int blockCount = 16;
	localparam int blockIdxWidth = 4;
	localparam int wordsPerBlock = 8;
	localparam int wordIdxWidth = 3;

	// Storage is addressed by the block index followed by the word index
	localparam int storageWords = blockCount * wordsPerBlock;
	localparam int storageAddrWidth = blockIdxWidth + wordIdxWidth;

	// Byte address on APB: identifier, block, word, then two zero bits
	localparam int addrWidth = clutIdWidth + storageAddrWidth + 2;

	typedef enum logic [1:0] {
		idle,
		setup,
		access,
		done
	} fillState;

endpackage

//--- hdl/clutSubsystem.sv
module clutSubsystem (
	input  logic clk,
	input  logic reset,
	input  logic [clutPkg::clutIdWidth-1:0] clutId,

	input  logic reqValid1,
	input  logic [clutPkg::indexWidth-1:0] reqIdx1,
	output logic reqReady1,
	output logic colorValid1,
	output logic [clutPkg::colorWidth-1:0] color1,

	input  logic reqValid2,
	input  logic [clutPkg::indexWidth-1:0] reqIdx2,
	output logic reqReady2,
	output logic colorValid2,
	output logic [clutPkg::colorWidth-1:0] color2,

	output logic pSel,
	output logic pEnable,
	output logic pWrite,
	output logic [clutPkg::addrWidth-1:0] pAddr,
	input  logic [clutPkg::wordWidth-1:0] pRdata,
	input  logic pReady
);

	logic clutChanged;

	clutFillIf fillBus ();

	clutCache cache (
		.clk(clk),
		.reset(reset),
		.clutId(clutId),
		.clutChanged(clutChanged),
		.fillPort(fillBus.cache),
		.reqValid1(reqValid1),
		.reqIdx1(reqIdx1),
		.reqReady1(reqReady1),
		.colorValid1(colorValid1),
		.color1(color1),
		.reqValid2(reqValid2),
		.reqIdx2(reqIdx2),
		.reqReady2(reqReady2),
		.colorValid2(colorValid2),
		.color2(color2)
	);

	// The texel ready lines are the hit indications for the fill controller
	clutFill fill (
		.clk(clk),
		.reset(reset),
		.clutId(clutId),
		.clutChanged(clutChanged),
		.reqValid1(reqValid1),
		.reqIdx1(reqIdx1),
		.hit1(reqReady1),
		.reqValid2(reqValid2),
		.reqIdx2(reqIdx2),
		.hit2(reqReady2),
		.fillPort(fillBus.fill),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pRdata(pRdata),
		.pReady(pReady)
	);

endmodule

//--- list.f
hdl/clutPkg.sv
hdl/clutFillIf.sv
hdl/clutCache.sv
hdl/clutFill.sv
hdl/clutSubsystem.sv
test/clutMemModel.sv
test/clutSubsystem_checker.sv
test/clutSubsystemTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module clutSubsystemTb -f list.f -o simv
status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi

//--- test/clutMemModel.sv
module clutMemModel (
	input  logic clk,
	input  logic reset,
	input  logic pSel,
	input  logic pEnable,
	input  logic [clutPkg::addrWidth-1:0] pAddr,
	output logic [clutPkg::wordWidth-1:0] pRdata,
	output logic pReady
);

	localparam logic [16:0] seed = 17'd99460;

	logic [16:0] lfsr;
	logic [16:0] lfsrOne;
	logic [16:0] lfsrTwo;
	logic [1:0] waitCount;
	logic [15:0] lowBits;

	// Fibonacci form of x^17 + x^14 + 1, the new bit enters at the bottom
	function automatic logic [16:0] lfsrStep(input logic [16:0] state);
		return {state[15:0], state[16] ^ state[13]};
	endfunction

	assign lfsrOne = lfsrStep(lfsr);
	assign lfsrTwo = lfsrStep(lfsrOne);

	// Two fresh bits per setup cycle give 0 to 3 wait states for the access
	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr <= seed;
			waitCount <= '0;
		end else if (pSel && !pEnable) begin
			lfsr <= lfsrTwo;
			waitCount <= {lfsrOne[0], lfsrTwo[0]};
		end else if (pSel && pEnable && (waitCount != 2'd0)) begin
			waitCount <= waitCount - 2'd1;
		end
	end

	assign pReady = pSel && pEnable && (waitCount == 2'd0);

	// Word address low bits in the low half, their inverse in the high half
	assign lowBits = pAddr[17:2];
	assign pRdata = {~lowBits, lowBits};

endmodule

//--- test/clutSubsystemTb.sv
module clutSubsystemTb;

	localparam int rowCount = 7;
	localparam int waitLimit = 300;

	// A request pair, the palette it runs under and the APB reads it should cost
	typedef struct packed {
		logic [clutPkg::clutIdWidth-1:0] id;
		logic valid1;
		logic [clutPkg::indexWidth-1:0] idx1;
		logic valid2;
		logic [clutPkg::indexWidth-1:0] idx2;
		logic [4:0] xfers;
		logic sweep;
	} testRow;

	// Miss and sweep, hit, double miss, palette change, same word halves,
	// double hit, then a miss on port 2 alone
	testRow stimulus [rowCount] = '{
		'{15'h1234, 1'b1, 8'h35, 1'b0, 8'h00, 5'd8, 1'b1},
		'{15'h1234, 1'b1, 8'h3a, 1'b0, 8'h00, 5'd0, 1'b0},
		'{15'h1234, 1'b1, 8'h72, 1'b1, 8'hc9, 5'd16, 1'b0},
		'{15'h5a5a, 1'b1, 8'h35, 1'b0, 8'h00, 5'd8, 1'b0},
		'{15'h5a5a, 1'b1, 8'h34, 1'b1, 8'h35, 5'd0, 1'b0},
		'{15'h5a5a, 1'b1, 8'h3f, 1'b1, 8'h30, 5'd0, 1'b0},
		'{15'h5a5a, 1'b0, 8'h00, 1'b1, 8'he1, 5'd8, 1'b0}
	};

	logic clk;
	logic reset;
	logic [clutPkg::clutIdWidth-1:0] clutId;
	logic reqValid1;
	logic [clutPkg::indexWidth-1:0] reqIdx1;
	logic reqReady1;
	logic colorValid1;
	logic [clutPkg::colorWidth-1:0] color1;
	logic reqValid2;
	logic [clutPkg::indexWidth-1:0] reqIdx2;
	logic reqReady2;
	logic colorValid2;
	logic [clutPkg::colorWidth-1:0] color2;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [clutPkg::addrWidth-1:0] pAddr;
	logic [clutPkg::wordWidth-1:0] pRdata;
	logic pReady;

	logic [clutPkg::addrWidth-1:0] addrLog [$];
	int testNum = 0;
	int testErrors = 0;
	int passCount = 0;
	int failCount = 0;
	bit timedOut = 1'b0;

	clutSubsystem UUT (.*);

	clutMemModel memory (
		.clk(clk),
		.reset(reset),
		.pSel(pSel),
		.pEnable(pEnable),
		.pAddr(pAddr),
		.pRdata(pRdata),
		.pReady(pReady)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Every completed APB read, in order, and the master never writes
	always @(posedge clk) begin
		if (!reset && (pWrite !== 1'b0)) begin
			reportMismatch("pWrite", pWrite, 0);
		end
		if (!reset && pSel && pEnable && pReady) begin
			addrLog.push_back(pAddr);
		end
	end

	function automatic logic [15:0] expectedColor(input logic [14:0] id,
			input logic [7:0] idx);
		logic [21:0] wordAddr;
		wordAddr = {id, idx[7:1]};
		return idx[0] ? ~wordAddr[15:0] : wordAddr[15:0];
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		$display("[FAIL] test %0d %s: got 0x%h, expected 0x%h", testNum, name, got, expected);
		testErrors++;
	endtask

	// With no block loaded, no index may be ready and the APB side stays quiet
	task automatic checkResetState();
		int i;
		for (i = 0; i < 256; i++) begin
			if (i % 64 == 0) begin
				@(posedge clk);
				if (pSel !== 1'b0) reportMismatch("pSel", pSel, 0);
				#5;
			end
			reqValid1 = 1'b1;
			reqValid2 = 1'b1;
			reqIdx1 = 8'(i);
			reqIdx2 = 8'(255 - i);
			#1;
			if (reqReady1 !== 1'b0) reportMismatch("reqReady1", reqReady1, 0);
			if (reqReady2 !== 1'b0) reportMismatch("reqReady2", reqReady2, 0);
			if (i % 64 == 63) begin
				reqValid1 = 1'b0;
				reqValid2 = 1'b0;
			end
		end
		@(posedge clk);
		if (pSel !== 1'b0) reportMismatch("pSel", pSel, 0);
		if (addrLog.size() != 0) reportMismatch("transfer count", addrLog.size(), 0);
	endtask

	task automatic request(input logic v1, input logic [7:0] i1, input logic v2,
			input logic [7:0] i2, input logic miss1, input logic miss2);
		logic pending1;
		logic pending2;
		logic due1;
		logic due2;
		int cycles;
		pending1 = v1;
		pending2 = v2;
		due1 = 1'b0;
		due2 = 1'b0;
		cycles = 0;
		@(posedge clk);
		#5;
		reqValid1 = v1;
		reqIdx1 = i1;
		reqValid2 = v2;
		reqIdx2 = i2;
		#1;
		if (v1 && (reqReady1 !== !miss1)) reportMismatch("reqReady1", reqReady1, !miss1);
		if (v2 && (reqReady2 !== !miss2)) reportMismatch("reqReady2", reqReady2, !miss2);
		while ((pending1 || pending2 || due1 || due2) && cycles < waitLimit) begin
			@(posedge clk);
			cycles++;
			if (colorValid1 !== due1) reportMismatch("colorValid1", colorValid1, due1);
			if (colorValid2 !== due2) reportMismatch("colorValid2", colorValid2, due2);
			if (due1 && (color1 !== expectedColor(clutId, i1))) begin
				reportMismatch("color1", color1, expectedColor(clutId, i1));
			end
			if (due2 && (color2 !== expectedColor(clutId, i2))) begin
				reportMismatch("color2", color2, expectedColor(clutId, i2));
			end
			due1 = pending1 && reqReady1;
			due2 = pending2 && reqReady2;
			pending1 = pending1 && !due1;
			pending2 = pending2 && !due2;
			#5;
			if (!pending1) reqValid1 = 1'b0;
			if (!pending2) reqValid2 = 1'b0;
		end
		if (pending1 || pending2 || due1 || due2) begin
			$display("Test %0d timed out waiting for a texel request to be served", testNum);
			testErrors++;
			timedOut = 1'b1;
		end
	endtask

	task automatic finishTest();
		if (testErrors == 0) begin
			passCount++;
			$display("test %0d: ok", testNum);
		end else begin
			failCount++;
			$display("test %0d: %0d errors", testNum, testErrors);
		end
	endtask

	initial begin
		int row;
		int j;
		int k;
		logic miss1;
		logic miss2;
		logic [3:0] firstBlk;
		logic [3:0] blk;
		reset = 1'b1;
		clutId = '0;
		reqValid1 = 1'b0;
		reqIdx1 = '0;
		reqValid2 = 1'b0;
		reqIdx2 = '0;
		repeat (2) @(posedge clk);
		#5;
		reset = 1'b0;
		checkResetState();
		finishTest();
		for (row = 0; row < rowCount && !timedOut; row++) begin
			testNum = row + 1;
			testErrors = 0;
			// The palette settles for one cycle before the requests arrive
			@(posedge clk);
			#5;
			clutId = stimulus[row].id;
			addrLog.delete();
			miss1 = stimulus[row].valid1 && (stimulus[row].xfers != 0);
			miss2 = (stimulus[row].xfers == 16)
				|| ((stimulus[row].xfers == 8) && !stimulus[row].valid1);
			request(stimulus[row].valid1, stimulus[row].idx1, stimulus[row].valid2,
				stimulus[row].idx2, miss1, miss2);
			if (stimulus[row].sweep) begin
				for (j = 0; j < 16 && !timedOut; j++) begin
					request(1'b1, {stimulus[row].idx1[7:4], 4'(j)}, 1'b0, 8'h00, 1'b0, 1'b0);
				end
			end
			if (addrLog.size() != stimulus[row].xfers) begin
				reportMismatch("transfer count", addrLog.size(), stimulus[row].xfers);
			end
			firstBlk = stimulus[row].valid1 ? stimulus[row].idx1[7:4]
				: stimulus[row].idx2[7:4];
			for (k = 0; k < addrLog.size() && k < stimulus[row].xfers; k++) begin
				blk = (k < 8) ? firstBlk : stimulus[row].idx2[7:4];
				if (addrLog[k] !== {stimulus[row].id, blk, 3'(k), 2'b00}) begin
					reportMismatch("pAddr", addrLog[k],
						{stimulus[row].id, blk, 3'(k), 2'b00});
				end
			end
			finishTest();
		end
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0 && !timedOut) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- test/clutSubsystem_checker.sv
module clutSubsystemChecker (
	input logic clk,
	input logic reset,
	input logic [clutPkg::clutIdWidth-1:0] clutId,
	input logic pSel,
	input logic pEnable,
	input logic pReady,
	input logic [clutPkg::addrWidth-1:0] pAddr,
	input logic reqValid1,
	input logic reqReady1,
	input logic colorValid1,
	input logic reqValid2,
	input logic reqReady2,
	input logic colorValid2,
	input clutPkg::fillState state,
	input logic fillWrite
);

	// An access cycle is always entered from a cycle that already had pSel high
	enableNeedsSelect: assert property (@(posedge clk) disable iff (reset)
		pEnable |-> (pSel && $past(pSel)))
		else $error("pEnable high without pSel and a preceding setup cycle");

	// The address may only move once the current transfer has completed
	addrStable: assert property (@(posedge clk) disable iff (reset)
		(pSel && !(pEnable && pReady)) |=> $stable(pAddr))
		else $error("pAddr changed inside an APB transfer");

	colorTiming1: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (colorValid1 == $past(reqValid1 && reqReady1)))
		else $error("colorValid1 does not follow acceptance by one cycle");

	colorTiming2: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (colorValid2 == $past(reqValid2 && reqReady2)))
		else $error("colorValid2 does not follow acceptance by one cycle");

	// A stored word must belong to the palette that is current when it arrives
	writeOnReady: assert property (@(posedge clk) disable iff (reset)
		fillWrite |-> ((state == clutPkg::access) && pReady
			&& (pAddr[clutPkg::addrWidth-1 -: clutPkg::clutIdWidth] == clutId)))
		else $error("fill write outside an access cycle with pReady or for a stale palette");

endmodule

bind clutSubsystem clutSubsystemChecker assertions (
	.clk(clk),
	.reset(reset),
	.clutId(clutId),
	.pSel(pSel),
	.pEnable(pEnable),
	.pReady(pReady),
	.pAddr(pAddr),
	.reqValid1(reqValid1),
	.reqReady1(reqReady1),
	.colorValid1(colorValid1),
	.reqValid2(reqValid2),
	.reqReady2(reqReady2),
	.colorValid2(colorValid2),
	.state(fill.state),
	.fillWrite(fillBus.write)
);
